// ==== hdl/rtab_pkg.sv ====
// Replay table package with table sizes, stored request and dependency types
`default_nettype none

package rtab_pkg;

    // Table depth, kept a power of two so pointers wrap naturally
    localparam int RTAB_ENTRIES = 4;
    localparam int PTR_W        = $clog2(RTAB_ENTRIES);

    // Cache-line index and requester tag widths
    localparam int NLINE_W = 8;
    localparam int ID_W    = 8;

    // Entry index
    typedef logic [PTR_W-1:0] rtab_ptr_t;

    // One bit per entry
    typedef logic [RTAB_ENTRIES-1:0] rtab_bv_t;

    // Cache-line index
    typedef logic [NLINE_W-1:0] rtab_nline_t;

    // Stored request, line index in the upper byte
    typedef struct packed {
        rtab_nline_t     nline;
        logic [ID_W-1:0] id;
    } rtab_req_t;

    // Pending dependencies of one entry
    //   mshr_hit   : waits for the refill of its own line
    //   mshr_ready : waits for the miss handler to accept a new miss
    typedef struct packed {
        logic mshr_hit;
        logic mshr_ready;
    } rtab_deps_t;

endpackage

`default_nettype wire

// ==== hdl/rtab_rr_arb.sv ====
// Round-robin arbiter that grants one ready list head per cycle, one-hot
`timescale 1ns/1ps
`default_nettype none

module rtab_rr_arb (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  rtab_pkg::rtab_bv_t req_i,
    input  logic               ready_i,
    output rtab_pkg::rtab_bv_t gnt_o
);
    import rtab_pkg::*;

    // Highest-priority index and the index granted this cycle
    rtab_ptr_t prio_q;
    rtab_ptr_t gnt_ptr;

    // Scan from the far end so the requester closest to prio_q wins last
    always_comb begin : grant_comb
        int idx;
        gnt_o   = '0;
        gnt_ptr = prio_q;
        for (int k = RTAB_ENTRIES - 1; k >= 0; k--) begin
            idx = (int'(prio_q) + k) % RTAB_ENTRIES;
            if (req_i[idx]) begin
                gnt_o      = '0;
                gnt_o[idx] = 1'b1;
                gnt_ptr    = rtab_ptr_t'(idx);
            end
        end
    end

    // Move priority just past the winner once the grant is taken
    always_ff @(posedge clk_i or negedge rst_ni) begin : prio_ff
        if (!rst_ni) begin
            prio_q <= '0;
        end else if (ready_i && |gnt_o) begin
            prio_q <= rtab_ptr_t'((int'(gnt_ptr) + 1) % RTAB_ENTRIES);
        end
    end

    // A taken grant always names exactly one entry
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(gnt_o) and (ready_i |-> $onehot(gnt_o)));

endmodule

`default_nettype wire

// ==== hdl/rtab_store.sv ====
// Replay table entry store with list links, dependency bits and line matching
`timescale 1ns/1ps
`default_nettype none

module rtab_store #(
    // Payload must carry an nline field for line matching
    parameter type payload_t = rtab_pkg::rtab_req_t
) (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    input  logic                                             cfg_single_entry_i,
    input  rtab_pkg::rtab_nline_t                            check_nline_i,
    output logic                                             check_hit_o,
    input  logic                                             alloc_i,
    input  logic                                             alloc_link_i,
    input  payload_t                                         alloc_req_i,
    input  rtab_pkg::rtab_deps_t                             alloc_deps_i,
    input  logic                                             refill_i,
    input  rtab_pkg::rtab_nline_t                            refill_nline_i,
    input  logic                                             miss_ready_i,
    input  rtab_pkg::rtab_bv_t                               try_bv_i,
    input  logic                                             commit_i,
    input  rtab_pkg::rtab_ptr_t                              commit_ptr_i,
    input  logic                                             rback_i,
    input  rtab_pkg::rtab_ptr_t                              rback_ptr_i,
    input  rtab_pkg::rtab_deps_t                             rback_deps_i,
    output rtab_pkg::rtab_bv_t                               ready_o,
    output rtab_pkg::rtab_bv_t                               tail_o,
    output rtab_pkg::rtab_ptr_t [rtab_pkg::RTAB_ENTRIES-1:0] next_o,
    output payload_t [rtab_pkg::RTAB_ENTRIES-1:0]            req_o,
    output logic                                             full_o,
    output logic                                             empty_o
);
    import rtab_pkg::*;

    // Payload and link storage
    payload_t   [RTAB_ENTRIES-1:0] req_q;
    rtab_ptr_t  [RTAB_ENTRIES-1:0] next_q;
    rtab_deps_t [RTAB_ENTRIES-1:0] deps_q;

    // Per-entry control state
    rtab_bv_t valid_q, head_q, tail_q;

    rtab_bv_t  free_bv, alloc_set, nodeps;
    rtab_bv_t  check_hit, tail_hit, refill_hit;
    rtab_bv_t  commit_bv, rback_bv, succ_head_set;
    rtab_ptr_t free_ptr;
    logic      alloc, new_head;

    assign alloc     = alloc_i | alloc_link_i;
    assign alloc_set = free_bv & {RTAB_ENTRIES{alloc}};

    // Lowest free entry, one-hot and as an index
    always_comb begin : free_pick
        free_bv  = '0;
        free_ptr = '0;
        for (int i = RTAB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_bv    = '0;
                free_bv[i] = 1'b1;
                free_ptr   = rtab_ptr_t'(i);
            end
        end
    end

    // Line compares, pointer decodes and the successor of a committed entry
    always_comb begin : match_comb
        succ_head_set = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            nodeps[i]     = ~|deps_q[i];
            check_hit[i]  = valid_q[i] && (req_q[i].nline == check_nline_i);
            refill_hit[i] = refill_i && valid_q[i] && (req_q[i].nline == refill_nline_i);
            commit_bv[i]  = commit_i && (commit_ptr_i == rtab_ptr_t'(i));
            rback_bv[i]   = rback_i && (rback_ptr_i == rtab_ptr_t'(i));
        end
        // Successor becomes a head if the walker did not take it already
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (commit_bv[i] && !tail_q[i]) begin
                succ_head_set[next_q[i]] = 1'b1;
            end
        end
    end

    assign tail_hit = check_hit & tail_q;

    // Linking behind a tail that leaves this cycle starts a fresh list
    assign new_head = alloc_i | (alloc_link_i & |(tail_hit & commit_bv));

    assign check_hit_o = |check_hit;
    assign ready_o     = valid_q & head_q & nodeps;
    assign tail_o      = tail_q;
    assign next_o      = next_q;
    assign req_o       = req_q;
    assign empty_o     = ~|valid_q;
    assign full_o      = (&valid_q) | (cfg_single_entry_i & |valid_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_ff
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            deps_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_set) & ~commit_bv;
            // Try takes the head away, rollback gives it back
            head_q  <= (head_q & ~try_bv_i & ~commit_bv & ~alloc_set)
                     | (alloc_set & {RTAB_ENTRIES{new_head}})
                     | (succ_head_set & ~try_bv_i)
                     | rback_bv;
            // Old tail of the line hands the tail bit to the new entry
            tail_q  <= (tail_q & ~(tail_hit & {RTAB_ENTRIES{alloc_link_i}}) & ~commit_bv)
                     | alloc_set;
            for (int i = 0; i < RTAB_ENTRIES; i++) begin
                if (alloc_set[i]) begin
                    deps_q[i] <= alloc_deps_i;
                end else if (rback_bv[i]) begin
                    deps_q[i] <= rback_deps_i;
                end else begin
                    if (refill_hit[i]) deps_q[i].mshr_hit <= 1'b0;
                    if (miss_ready_i) deps_q[i].mshr_ready <= 1'b0;
                end
            end
        end
    end

    // Payload written at allocation, next pointer at link time
    always_ff @(posedge clk_i) begin : data_ff
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (alloc_set[i]) begin
                req_q[i] <= alloc_req_i;
            end
            if (alloc_link_i && tail_hit[i]) begin
                next_q[i] <= free_ptr;
            end
        end
    end

    a_one_tail: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> $onehot(tail_hit));
    a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc |-> !full_o);
    a_no_link_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> !cfg_single_entry_i);
    a_pop_valid_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_i |-> valid_q[commit_ptr_i]) and (rback_i |-> valid_q[rback_ptr_i]));

endmodule

`default_nettype wire

// ==== hdl/rtab_pop_ctrl.sv ====
// Pop controller FSM that offers list heads and walks each list in order
`timescale 1ns/1ps
`default_nettype none

module rtab_pop_ctrl (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    input  rtab_pkg::rtab_bv_t                               gnt_i,
    input  rtab_pkg::rtab_bv_t                               ready_i,
    input  rtab_pkg::rtab_bv_t                               tail_i,
    input  rtab_pkg::rtab_ptr_t [rtab_pkg::RTAB_ENTRIES-1:0] next_i,
    input  logic                                             pop_try_i,
    input  logic                                             pop_rback_i,
    output logic                                             arb_ready_o,
    output logic                                             pop_valid_o,
    output rtab_pkg::rtab_bv_t                               pop_sel_o,
    output rtab_pkg::rtab_ptr_t                              pop_ptr_o
);
    import rtab_pkg::*;

    // Head choice, successor offer, successor held under back-pressure
    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_WAIT
    } pop_state_e;

    pop_state_e state_q, state_d;
    rtab_bv_t   next_q, next_d;
    rtab_bv_t   succ_bv;
    logic       sel_tail;

    // Heads come from the arbiter, list members from the saved successor
    assign pop_sel_o   = (state_q == POP_HEAD) ? gnt_i : next_q;
    assign pop_valid_o = (state_q == POP_HEAD) ? |ready_i : 1'b1;
    assign sel_tail    = |(pop_sel_o & tail_i);

    // Offered index and its successor as a one-hot vector
    always_comb begin : ptr_comb
        pop_ptr_o = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (pop_sel_o[i]) pop_ptr_o = rtab_ptr_t'(i);
        end
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            succ_bv[i] = (next_i[pop_ptr_o] == rtab_ptr_t'(i));
        end
    end

    always_comb begin : fsm_comb
        state_d     = state_q;
        next_d      = next_q;
        arb_ready_o = 1'b0;
        case (state_q)
            POP_HEAD: begin
                if (pop_try_i && pop_valid_o && !pop_rback_i) begin
                    arb_ready_o = 1'b1;
                    if (!sel_tail) begin
                        state_d = POP_NEXT;
                        next_d  = succ_bv;
                    end
                end
            end
            POP_NEXT, POP_WAIT: begin
                if (pop_rback_i) begin
                    // Predecessor went back, its list restarts from the head
                    state_d = POP_HEAD;
                end else if (pop_try_i) begin
                    state_d = sel_tail ? POP_HEAD : POP_NEXT;
                    if (!sel_tail) next_d = succ_bv;
                end else begin
                    state_d = POP_WAIT;
                end
            end
            default: state_d = POP_HEAD;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_ff
        if (!rst_ni) begin
            state_q <= POP_HEAD;
            next_q  <= '0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
        end
    end

    // Rollback only answers the try of the previous cycle
    a_rback_after_try: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> $past(pop_try_i));

endmodule

`default_nettype wire

// ==== hdl/rtab_top.sv ====
// Replay table top joining the entry store, the pop FSM and the head arbiter
`timescale 1ns/1ps
`default_nettype none

module rtab_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  cfg_single_entry_i,
    input  logic                  check_i,
    input  rtab_pkg::rtab_nline_t check_nline_i,
    output logic                  check_hit_o,
    input  logic                  alloc_i,
    input  logic                  alloc_link_i,
    input  rtab_pkg::rtab_req_t   alloc_req_i,
    input  rtab_pkg::rtab_deps_t  alloc_deps_i,
    output logic                  pop_valid_o,
    input  logic                  pop_try_i,
    output rtab_pkg::rtab_req_t   pop_req_o,
    output rtab_pkg::rtab_ptr_t   pop_ptr_o,
    input  logic                  pop_commit_i,
    input  rtab_pkg::rtab_ptr_t   pop_commit_ptr_i,
    input  logic                  pop_rback_i,
    input  rtab_pkg::rtab_ptr_t   pop_rback_ptr_i,
    input  rtab_pkg::rtab_deps_t  rback_deps_i,
    input  logic                  refill_i,
    input  rtab_pkg::rtab_nline_t refill_nline_i,
    input  logic                  miss_ready_i,
    output logic                  full_o,
    output logic                  empty_o
);
    import rtab_pkg::*;

    rtab_req_t [RTAB_ENTRIES-1:0] req;
    rtab_ptr_t [RTAB_ENTRIES-1:0] next;
    rtab_bv_t                     ready, tail, gnt, pop_sel, try_bv;
    logic                         arb_ready, line_hit;

    // Hit only answered while a check is requested
    assign check_hit_o = check_i & line_hit;
    assign try_bv      = pop_sel & {RTAB_ENTRIES{pop_try_i}};

    // One-hot payload select for the offered entry
    always_comb begin : pop_req_mux
        pop_req_o = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (pop_sel[i]) pop_req_o = pop_req_o | req[i];
        end
    end

    rtab_store #(
        .payload_t (rtab_req_t)
    ) u_store (
        .clk_i, .rst_ni, .cfg_single_entry_i, .check_nline_i,
        .check_hit_o  (line_hit),
        .alloc_i, .alloc_link_i, .alloc_req_i, .alloc_deps_i,
        .refill_i, .refill_nline_i, .miss_ready_i,
        .try_bv_i     (try_bv),
        .commit_i     (pop_commit_i),
        .commit_ptr_i (pop_commit_ptr_i),
        .rback_i      (pop_rback_i),
        .rback_ptr_i  (pop_rback_ptr_i),
        .rback_deps_i,
        .ready_o      (ready),
        .tail_o       (tail),
        .next_o       (next),
        .req_o        (req),
        .full_o, .empty_o
    );

    rtab_rr_arb u_arb (
        .clk_i, .rst_ni,
        .req_i   (ready),
        .ready_i (arb_ready),
        .gnt_o   (gnt)
    );

    rtab_pop_ctrl u_pop_ctrl (
        .clk_i, .rst_ni,
        .gnt_i       (gnt),
        .ready_i     (ready),
        .tail_i      (tail),
        .next_i      (next),
        .pop_try_i, .pop_rback_i,
        .arb_ready_o (arb_ready),
        .pop_valid_o,
        .pop_sel_o   (pop_sel),
        .pop_ptr_o
    );

    // Every accepted offer is settled on the next cycle
    a_try_settled: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_try_i |=> (pop_commit_i || pop_rback_i));

endmodule

`default_nettype wire

// ==== dv/rtab_tb.sv ====
// Replay table testbench that replays stimulus records against a per-line scoreboard
`timescale 1ns/1ps
`default_nettype none

module rtab_tb;
    import rtab_pkg::*;

    localparam int MAX_REC    = 64;
    localparam int REC_CYCLES = 30;
    localparam int NLINES     = 1 << NLINE_W;

    // Record command codes sit in the first word of each record
    localparam logic [15:0] CMD_RESET  = 16'h0001;
    localparam logic [15:0] CMD_ALLOC  = 16'h0002;
    localparam logic [15:0] CMD_LINK   = 16'h0003;
    localparam logic [15:0] CMD_REFILL = 16'h0004;
    localparam logic [15:0] CMD_MISSRD = 16'h0005;
    localparam logic [15:0] CMD_SINGLE = 16'h0006;
    localparam logic [15:0] CMD_DRAIN  = 16'h0007;
    localparam logic [15:0] CMD_STATUS = 16'h0008;
    localparam logic [15:0] CMD_QUIET  = 16'h0009;
    localparam logic [15:0] CMD_END    = 16'h000f;

    logic        clk_i;
    logic        rst_ni;
    logic        cfg_single_entry_i;
    logic        check_i;
    rtab_nline_t check_nline_i;
    logic        check_hit_o;
    logic        alloc_i;
    logic        alloc_link_i;
    rtab_req_t   alloc_req_i;
    rtab_deps_t  alloc_deps_i;
    logic        pop_valid_o;
    logic        pop_try_i;
    rtab_req_t   pop_req_o;
    rtab_ptr_t   pop_ptr_o;
    logic        pop_commit_i;
    rtab_ptr_t   pop_commit_ptr_i;
    logic        pop_rback_i;
    rtab_ptr_t   pop_rback_ptr_i;
    rtab_deps_t  rback_deps_i;
    logic        refill_i;
    rtab_nline_t refill_nline_i;
    logic        miss_ready_i;
    logic        full_o;
    logic        empty_o;

    // Four words per record hold a command and three arguments
    logic [15:0] stim_mem [0:4*MAX_REC-1];

    // Scoreboard queues of pending ids, dependency bits and entries per line in arrival order
    logic [ID_W-1:0] line_ids  [0:NLINES-1][$];
    rtab_deps_t      line_deps [0:NLINES-1][$];
    rtab_ptr_t       line_ptrs [0:NLINES-1][$];

    // Entry model with occupied slots and the line held in each
    rtab_bv_t        used_bv;
    rtab_nline_t     slot_line [RTAB_ENTRIES];

    int mismatch_cnt;
    int fail_cnt;
    int cycle_cnt;
    int cycle_limit;
    int num_rec;

    rtab_top DUT (.*);

    always #2 clk_i = ~clk_i;

    // Run limit scales with the number of records
    always @(posedge clk_i) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
            report_counts();
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_req(input string name, input rtab_req_t exp, input rtab_req_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ptr(input string name, input rtab_ptr_t exp, input rtab_ptr_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_fail(input string msg);
        fail_cnt++;
        $display("error: %s", msg);
    endtask

    task automatic report_counts();
        $display("error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    endtask

    // New requests take the lowest free entry
    function automatic rtab_ptr_t pick_free_slot();
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (!used_bv[i]) return rtab_ptr_t'(i);
        end
        return '0;
    endfunction

    // Drop all strobes right after a rising edge
    task automatic drive_idle();
        check_i      <= 1'b0;
        alloc_i      <= 1'b0;
        alloc_link_i <= 1'b0;
        refill_i     <= 1'b0;
        miss_ready_i <= 1'b0;
        pop_try_i    <= 1'b0;
        pop_commit_i <= 1'b0;
        pop_rback_i  <= 1'b0;
    endtask

    task automatic apply_reset(input string name, input rtab_nline_t line);
        @(posedge clk_i);
        drive_idle();
        rst_ni <= 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni        <= 1'b1;
        check_i       <= 1'b1;
        check_nline_i <= line;
        for (int l = 0; l < NLINES; l++) begin
            line_ids[l].delete();
            line_deps[l].delete();
            line_ptrs[l].delete();
        end
        used_bv = '0;
        @(negedge clk_i);
        check_bit({name, " reset empty"}, 1'b1, empty_o);
        check_bit({name, " reset full"}, 1'b0, full_o);
        check_bit({name, " reset pop valid"}, 1'b0, pop_valid_o);
        check_bit({name, " reset check hit"}, 1'b0, check_hit_o);
        @(posedge clk_i);
        drive_idle();
    endtask

    // Check and allocate in one cycle with a hit expected when the line has pending ids
    task automatic alloc_entry(input string name, input logic link, input rtab_nline_t line,
                               input logic [ID_W-1:0] id, input rtab_deps_t deps);
        logic      exp_hit;
        rtab_ptr_t slot;
        exp_hit = (line_ids[line].size() != 0);
        slot    = pick_free_slot();
        @(posedge clk_i);
        check_i       <= 1'b1;
        check_nline_i <= line;
        alloc_i       <= !link;
        alloc_link_i  <= link;
        alloc_req_i   <= {line, id};
        alloc_deps_i  <= deps;
        @(negedge clk_i);
        check_bit({name, " check hit"}, exp_hit, check_hit_o);
        @(posedge clk_i);
        drive_idle();
        line_ids[line].push_back(id);
        line_deps[line].push_back(deps);
        line_ptrs[line].push_back(slot);
        used_bv[slot]   = 1'b1;
        slot_line[slot] = line;
    endtask

    task automatic pulse_refill(input rtab_nline_t line);
        @(posedge clk_i);
        refill_i       <= 1'b1;
        refill_nline_i <= line;
        @(posedge clk_i);
        drive_idle();
        // Refill only releases its own line
        for (int k = 0; k < line_deps[line].size(); k++) begin
            line_deps[line][k] = rtab_deps_t'(line_deps[line][k] & 2'b01);
        end
    endtask

    task automatic pulse_miss_ready();
        @(posedge clk_i);
        miss_ready_i <= 1'b1;
        @(posedge clk_i);
        drive_idle();
        for (int l = 0; l < NLINES; l++) begin
            for (int k = 0; k < line_deps[l].size(); k++) begin
                line_deps[l][k] = rtab_deps_t'(line_deps[l][k] & 2'b10);
            end
        end
    endtask

    task automatic check_status(input string name, input logic exp_empty,
                                input logic exp_full, input logic exp_valid);
        @(negedge clk_i);
        check_bit({name, " empty"}, exp_empty, empty_o);
        check_bit({name, " full"}, exp_full, full_o);
        check_bit({name, " pop valid"}, exp_valid, pop_valid_o);
        @(posedge clk_i);
    endtask

    task automatic check_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            check_bit({name, " quiet pop valid"}, 1'b0, pop_valid_o);
        end
        @(posedge clk_i);
    endtask

    // Consumer accepts at random and commits or rolls back one cycle after the try
    task automatic drain(input string name, input int pops, input int rbacks);
        int          done_cnt;
        int          rb_left;
        logic        have_exp;
        rtab_req_t   got;
        rtab_req_t   exp;
        rtab_ptr_t   ptr;
        rtab_ptr_t   slot;
        rtab_nline_t line;
        done_cnt = 0;
        rb_left  = rbacks;
        while (done_cnt < pops) begin
            @(negedge clk_i);
            if (pop_valid_o && ($urandom % 4 != 0)) begin
                @(posedge clk_i);
                pop_try_i <= 1'b1;
                @(negedge clk_i);
                check_bit({name, " valid under try"}, 1'b1, pop_valid_o);
                got      = pop_req_o;
                ptr      = pop_ptr_o;
                line     = slot_line[ptr];
                have_exp = used_bv[ptr] && (line_ids[line].size() != 0);
                // Offered entry must hold the oldest pending request of its line
                if (!have_exp) begin
                    report_fail($sformatf("%s: free entry %0d offered", name, ptr));
                end else begin
                    exp = {line, line_ids[line][0]};
                    check_req({name, " pop payload"}, exp, got);
                    check_ptr({name, " pop pointer"}, line_ptrs[line][0], ptr);
                    if (line_deps[line][0] != '0) begin
                        report_fail($sformatf("%s: line %h offered with dependencies pending",
                                              name, line));
                    end
                end
                @(posedge clk_i);
                pop_try_i <= 1'b0;
                if (rb_left > 0) begin
                    pop_rback_i     <= 1'b1;
                    pop_rback_ptr_i <= ptr;
                    rback_deps_i    <= '0;
                    rb_left--;
                end else begin
                    pop_commit_i     <= 1'b1;
                    pop_commit_ptr_i <= ptr;
                    done_cnt++;
                    if (have_exp) begin
                        void'(line_ids[line].pop_front());
                        void'(line_deps[line].pop_front());
                        slot          = line_ptrs[line].pop_front();
                        used_bv[slot] = 1'b0;
                    end
                end
                @(posedge clk_i);
                pop_commit_i <= 1'b0;
                pop_rback_i  <= 1'b0;
            end
        end
    endtask

    initial begin : stimulus
        logic [15:0] cmd;
        logic [15:0] a0;
        logic [15:0] a1;
        logic [15:0] a2;
        string       name;
        clk_i              = 1'b0;
        rst_ni             = 1'b0;
        cfg_single_entry_i = 1'b0;
        check_i            = 1'b0;
        check_nline_i      = '0;
        alloc_i            = 1'b0;
        alloc_link_i       = 1'b0;
        alloc_req_i        = '0;
        alloc_deps_i       = '0;
        pop_try_i          = 1'b0;
        pop_commit_i       = 1'b0;
        pop_commit_ptr_i   = '0;
        pop_rback_i        = 1'b0;
        pop_rback_ptr_i    = '0;
        rback_deps_i       = '0;
        refill_i           = 1'b0;
        refill_nline_i     = '0;
        miss_ready_i       = 1'b0;
        used_bv            = '0;
        mismatch_cnt       = 0;
        fail_cnt           = 0;
        cycle_cnt          = 0;
        cycle_limit        = REC_CYCLES * MAX_REC;
        void'($urandom(63));
        $readmemh("dv/rtab_stim.txt", stim_mem);
        // Records run up to the end command
        num_rec = 0;
        while (num_rec < MAX_REC && stim_mem[4*num_rec] !== CMD_END
               && !$isunknown(stim_mem[4*num_rec])) begin
            num_rec++;
        end
        if (num_rec == 0) begin
            report_fail("stimulus file holds no records");
        end
        cycle_limit = REC_CYCLES * (num_rec + 1);
        for (int r = 0; r < num_rec; r++) begin
            cmd  = stim_mem[4*r];
            a0   = stim_mem[4*r+1];
            a1   = stim_mem[4*r+2];
            a2   = stim_mem[4*r+3];
            name = $sformatf("rec%0d", r);
            case (cmd)
                CMD_RESET:  apply_reset(name, a0[7:0]);
                CMD_ALLOC:  alloc_entry(name, 1'b0, a0[7:0], a1[7:0], rtab_deps_t'(a2[1:0]));
                CMD_LINK:   alloc_entry(name, 1'b1, a0[7:0], a1[7:0], rtab_deps_t'(a2[1:0]));
                CMD_REFILL: pulse_refill(a0[7:0]);
                CMD_MISSRD: pulse_miss_ready();
                CMD_SINGLE: begin
                    @(posedge clk_i);
                    cfg_single_entry_i <= a0[0];
                end
                CMD_DRAIN:  drain(name, int'(a0), int'(a1));
                CMD_STATUS: check_status(name, a0[0], a1[0], a2[0]);
                CMD_QUIET:  check_quiet(name, int'(a0));
                default:    report_fail($sformatf("%s: unknown command %h", name, cmd));
            endcase
        end
        report_counts();
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/rtab_stim.txt ====
// cmd a0 a1 a2, hex: 1 reset(line) 2 alloc(line,id,deps) 3 link(line,id,deps) 4 refill(line)
// 5 miss-ready 6 single(on) 7 drain(pops,rollbacks) 8 status(empty,full,valid) 9 quiet(cycles) f end
1 10 0 0
2 10 1 0
2 20 2 0
2 30 3 0
2 40 4 0
8 0 1 1
7 4 0 0
8 1 0 0
2 55 11 0
3 55 12 0
3 55 13 0
7 3 1 0
8 1 0 0
// deps: 2 waits for refill, 1 waits for miss handler
2 66 21 2
2 77 22 1
4 88 0 0
9 8 0 0
4 66 0 0
7 1 0 0
8 0 0 0
5 0 0 0
7 1 0 0
8 1 0 0
6 1 0 0
2 99 31 0
8 0 1 1
7 1 0 0
8 1 0 0
f 0 0 0

// ==== filelist.f ====
hdl/rtab_pkg.sv
hdl/rtab_rr_arb.sv
hdl/rtab_store.sv
hdl/rtab_pop_ctrl.sv
hdl/rtab_top.sv
dv/rtab_tb.sv

// ==== Bender.yml ====
package:
  name: rtab

sources:
  - hdl/rtab_pkg.sv
  - hdl/rtab_rr_arb.sv
  - hdl/rtab_store.sv
  - hdl/rtab_pop_ctrl.sv
  - hdl/rtab_top.sv
  - target: test
    files:
      - dv/rtab_tb.sv
